// File: design/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

`define CONV_DWIDTH      32
`define CONV_AWIDTH      14
`define CONV_MEM_DEPTH   16384

`define CONV_WT_DIM      3
`define CONV_MAX_FM_DIM  16

`define CONV_REG_SEL_BIT 31    // host word address bit for the register window

`define CONV_REG_CTRL    0     // bit 0 starts a run
`define CONV_REG_STATUS  1     // bit 0 idle, bit 1 done
`define CONV_REG_FM_DIM  2
`define CONV_REG_WT_OFS  3
`define CONV_REG_IFM_OFS 4
`define CONV_REG_OFM_OFS 5

`endif

// File: design/conv_engine.sv
`include "conv_config.svh"

module conv_engine (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              start_i,
    input  conv_pkg::cfg_t    cfg_i,
    output logic              idle_o,
    output logic              done_o,
    output logic              rd_req_valid_o,
    output conv_pkg::rd_req_t rd_req_o,
    input  logic              rd_req_ready_i,
    input  logic              rd_data_valid_i,
    input  conv_pkg::word_t   rd_data_i,
    output logic              rd_data_ready_o,
    output logic              wr_req_valid_o,
    output conv_pkg::wr_req_t wr_req_o,
    input  logic              wr_req_ready_i,
    output logic              wr_data_valid_o,
    output conv_pkg::word_t   wr_data_o,
    input  logic              wr_data_ready_i,
    input  logic              wr_resp_valid_i,
    output logic              wr_resp_ready_o
);
    localparam int NUM_WT = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam logic [1:0] LAST_K = 2'(`CONV_WT_DIM - 1);

    conv_pkg::eng_state_t            state;
    conv_pkg::word_t                 wt [NUM_WT];
    logic signed [`CONV_DWIDTH-1:0] acc;
    logic [3:0] row;
    logic [3:0] col;
    logic [1:0] krow;    // kernel row, also steps the weight load
    logic [1:0] kcol;
    logic       sent;    // weight request or result word already taken

    logic [4:0]      out_dim;
    logic [3:0]      wt_sel;
    logic            rd_beat;
    logic            last_col;
    logic            last_row;
    conv_pkg::addr_t row_addr;
    conv_pkg::addr_t out_addr;

    assign out_dim  = cfg_i.fm_dim - 5'(`CONV_WT_DIM - 1);
    assign last_col = ({1'b0, col} == out_dim - 5'd1);
    assign last_row = ({1'b0, row} == out_dim - 5'd1);
    assign wt_sel   = 4'(krow) * 4'(`CONV_WT_DIM) + 4'(kcol);
    assign rd_beat  = rd_data_valid_i && rd_data_ready_o;

    assign row_addr = cfg_i.ifm_ofs + conv_pkg::addr_t'(col) +
                      (conv_pkg::addr_t'(row) + conv_pkg::addr_t'(krow)) *
                      conv_pkg::addr_t'(cfg_i.fm_dim);
    assign out_addr = cfg_i.ofm_ofs + conv_pkg::addr_t'(col) +
                      conv_pkg::addr_t'(row) * conv_pkg::addr_t'(out_dim);

    assign idle_o          = (state == conv_pkg::IDLE);
    assign rd_req_valid_o  = (state == conv_pkg::LOAD_WT && !sent) ||
                             (state == conv_pkg::READ_ROW);
    assign rd_req_o        = (state == conv_pkg::LOAD_WT) ?
                             conv_pkg::rd_req_t'{cfg_i.wt_ofs, conv_pkg::len_t'(NUM_WT)} :
                             conv_pkg::rd_req_t'{row_addr, conv_pkg::len_t'(`CONV_WT_DIM)};
    assign rd_data_ready_o = (state == conv_pkg::LOAD_WT) || (state == conv_pkg::ACCUM);
    assign wr_req_valid_o  = (state == conv_pkg::WRITE);
    assign wr_req_o        = conv_pkg::wr_req_t'{out_addr, conv_pkg::len_t'(1)};
    assign wr_data_valid_o = (state == conv_pkg::WAIT_WR) && !sent;
    assign wr_data_o       = conv_pkg::word_t'(acc);
    assign wr_resp_ready_o = (state == conv_pkg::WAIT_WR);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= conv_pkg::IDLE;
            done_o <= 1'b0;
            sent   <= 1'b0;
            row    <= '0;
            col    <= '0;
            krow   <= '0;
            kcol   <= '0;
        end else begin
            done_o <= 1'b0;
            if (rd_beat) begin    // kernel position steps on every word in
                if (kcol == LAST_K) begin
                    kcol <= '0;
                    krow <= (krow == LAST_K) ? 2'd0 : krow + 2'd1;
                end else begin
                    kcol <= kcol + 2'd1;
                end
            end
            case (state)
                conv_pkg::IDLE: begin
                    if (start_i) begin
                        state <= conv_pkg::LOAD_WT;
                        sent  <= 1'b0;
                        row   <= '0;
                        col   <= '0;
                        krow  <= '0;
                        kcol  <= '0;
                    end
                end
                conv_pkg::LOAD_WT: begin
                    if (rd_req_valid_o && rd_req_ready_i) begin
                        sent <= 1'b1;
                    end
                    if (rd_beat && krow == LAST_K && kcol == LAST_K) begin
                        state <= conv_pkg::READ_ROW;
                    end
                end
                conv_pkg::READ_ROW: begin
                    if (rd_req_ready_i) begin
                        state <= conv_pkg::ACCUM;
                    end
                end
                conv_pkg::ACCUM: begin
                    if (rd_beat && kcol == LAST_K) begin
                        state <= (krow == LAST_K) ? conv_pkg::WRITE : conv_pkg::READ_ROW;
                    end
                end
                conv_pkg::WRITE: begin
                    if (wr_req_ready_i) begin
                        state <= conv_pkg::WAIT_WR;
                        sent  <= 1'b0;
                    end
                end
                conv_pkg::WAIT_WR: begin
                    if (wr_data_valid_o && wr_data_ready_i) begin
                        sent <= 1'b1;
                    end
                    if (wr_resp_valid_i) begin    // next pixel, row-major
                        state <= conv_pkg::READ_ROW;
                        col   <= last_col ? 4'd0 : col + 4'd1;
                        if (last_col) begin
                            row <= row + 4'd1;
                            if (last_row) begin
                                state  <= conv_pkg::IDLE;
                                done_o <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= conv_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == conv_pkg::LOAD_WT && rd_beat) begin
            wt[wt_sel] <= rd_data_i;
        end
        if (state == conv_pkg::READ_ROW && krow == 2'd0) begin
            acc <= '0;    // first row of a new pixel
        end else if (state == conv_pkg::ACCUM && rd_beat) begin
            acc <= acc + $signed(wt[wt_sel]) * $signed(rd_data_i);    // wraps mod 2^32
        end
    end

endmodule

// File: design/conv_pkg.sv
`include "conv_config.svh"

package conv_pkg;

    typedef logic [`CONV_DWIDTH-1:0] word_t;
    typedef logic [`CONV_AWIDTH-1:0] addr_t;
    typedef logic [4:0]              len_t;    // burst length, up to 16 words

    typedef struct packed {
        logic [31:0] addr;    // bit 31 picks registers, low bits are the word address
        word_t       wdata;
        logic        we;
    } host_req_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } rd_req_t;

    typedef rd_req_t wr_req_t;

    typedef struct packed {
        logic [4:0] fm_dim;
        addr_t      wt_ofs;
        addr_t      ifm_ofs;
        addr_t      ofm_ofs;
    } cfg_t;

    typedef enum logic [2:0] {
        IDLE, LOAD_WT, READ_ROW, ACCUM, WRITE, WAIT_WR
    } eng_state_t;

endpackage

// File: design/conv_regs.sv
`include "conv_config.svh"

module conv_regs (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            wr_en_i,
    input  logic            rd_en_i,
    input  logic [2:0]      reg_idx_i,
    input  conv_pkg::word_t wdata_i,
    input  logic            idle_i,
    input  logic            done_i,
    output conv_pkg::word_t rdata_o,
    output conv_pkg::cfg_t  cfg_o,
    output logic            start_o
);
    logic done_q;     // sticky until the next start
    logic fm_ok;
    logic start_req;

    assign fm_ok = (cfg_o.fm_dim >= 5'(`CONV_WT_DIM)) &&
                   (cfg_o.fm_dim <= 5'(`CONV_MAX_FM_DIM));

    // start_o is checked too, the engine leaves idle one cycle after the pulse
    assign start_req = wr_en_i && (reg_idx_i == 3'(`CONV_REG_CTRL)) && wdata_i[0] &&
                       idle_i && !start_o && fm_ok;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_o   <= '0;
            start_o <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_o <= start_req;
            if (start_req) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
            if (wr_en_i) begin
                case (reg_idx_i)
                    3'(`CONV_REG_FM_DIM):  cfg_o.fm_dim  <= wdata_i[4:0];
                    3'(`CONV_REG_WT_OFS):  cfg_o.wt_ofs  <= wdata_i[`CONV_AWIDTH-1:0];
                    3'(`CONV_REG_IFM_OFS): cfg_o.ifm_ofs <= wdata_i[`CONV_AWIDTH-1:0];
                    3'(`CONV_REG_OFM_OFS): cfg_o.ofm_ofs <= wdata_i[`CONV_AWIDTH-1:0];
                    default: ;    // ctrl handled by start_req
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            case (reg_idx_i)
                3'(`CONV_REG_STATUS):  rdata_o <= {{(`CONV_DWIDTH-2){1'b0}}, done_q, idle_i};
                3'(`CONV_REG_FM_DIM):  rdata_o <= conv_pkg::word_t'(cfg_o.fm_dim);
                3'(`CONV_REG_WT_OFS):  rdata_o <= conv_pkg::word_t'(cfg_o.wt_ofs);
                3'(`CONV_REG_IFM_OFS): rdata_o <= conv_pkg::word_t'(cfg_o.ifm_ofs);
                3'(`CONV_REG_OFM_OFS): rdata_o <= conv_pkg::word_t'(cfg_o.ofm_ofs);
                default:               rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: design/conv_top.sv
`include "conv_config.svh"

module conv_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                host_valid_i,
    input  conv_pkg::host_req_t host_req_i,
    output conv_pkg::word_t     host_rdata_o,
    output logic                host_rvalid_o
);
    logic              reg_sel;
    logic              reg_sel_q;    // picks the read word one cycle later
    conv_pkg::word_t   reg_rdata;
    conv_pkg::word_t   ram_a_rdata;
    conv_pkg::cfg_t    cfg;
    logic              start;
    logic              idle;
    logic              done_pulse;
    logic              rd_req_valid, rd_req_ready;
    conv_pkg::rd_req_t rd_req;
    logic              rd_data_valid, rd_data_ready;
    conv_pkg::word_t   rd_data;
    logic              wr_req_valid, wr_req_ready;
    conv_pkg::wr_req_t wr_req;
    logic              wr_data_valid, wr_data_ready;
    conv_pkg::word_t   wr_data;
    logic              wr_resp_valid, wr_resp_ready;
    conv_pkg::addr_t   ram_b_addr;
    logic              ram_b_we;
    conv_pkg::word_t   ram_b_wdata;
    conv_pkg::word_t   ram_b_rdata;

    assign reg_sel      = host_req_i.addr[`CONV_REG_SEL_BIT];
    assign host_rdata_o = reg_sel_q ? reg_rdata : ram_a_rdata;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            host_rvalid_o <= 1'b0;
        end else begin
            host_rvalid_o <= host_valid_i && !host_req_i.we;
        end
    end

    always_ff @(posedge clk) begin
        reg_sel_q <= reg_sel;
    end

    conv_regs i_regs (
        .clk(clk), .rst_i(rst_i),
        .wr_en_i(host_valid_i && host_req_i.we && reg_sel),
        .rd_en_i(host_valid_i && !host_req_i.we && reg_sel),
        .reg_idx_i(host_req_i.addr[2:0]), .wdata_i(host_req_i.wdata),
        .idle_i(idle), .done_i(done_pulse),
        .rdata_o(reg_rdata), .cfg_o(cfg), .start_o(start)
    );

    conv_engine i_engine (
        .clk(clk), .rst_i(rst_i),
        .start_i(start), .cfg_i(cfg), .idle_o(idle), .done_o(done_pulse),
        .rd_req_valid_o(rd_req_valid), .rd_req_o(rd_req), .rd_req_ready_i(rd_req_ready),
        .rd_data_valid_i(rd_data_valid), .rd_data_i(rd_data),
        .rd_data_ready_o(rd_data_ready),
        .wr_req_valid_o(wr_req_valid), .wr_req_o(wr_req), .wr_req_ready_i(wr_req_ready),
        .wr_data_valid_o(wr_data_valid), .wr_data_o(wr_data),
        .wr_data_ready_i(wr_data_ready),
        .wr_resp_valid_i(wr_resp_valid), .wr_resp_ready_o(wr_resp_ready)
    );

    dmem_ctrl i_ctrl (
        .clk(clk), .rst_i(rst_i),
        .rd_req_valid_i(rd_req_valid), .rd_req_i(rd_req), .rd_req_ready_o(rd_req_ready),
        .rd_data_valid_o(rd_data_valid), .rd_data_o(rd_data),
        .rd_data_ready_i(rd_data_ready),
        .wr_req_valid_i(wr_req_valid), .wr_req_i(wr_req), .wr_req_ready_o(wr_req_ready),
        .wr_data_valid_i(wr_data_valid), .wr_data_i(wr_data),
        .wr_data_ready_o(wr_data_ready),
        .wr_resp_valid_o(wr_resp_valid), .wr_resp_ready_i(wr_resp_ready),
        .ram_addr_o(ram_b_addr), .ram_we_o(ram_b_we),
        .ram_wdata_o(ram_b_wdata), .ram_rdata_i(ram_b_rdata)
    );

    dmem_ram i_ram (
        .clk(clk),
        .a_addr_i(host_req_i.addr[`CONV_AWIDTH-1:0]),
        .a_we_i(host_valid_i && host_req_i.we && !reg_sel),
        .a_wdata_i(host_req_i.wdata), .a_rdata_o(ram_a_rdata),
        .b_addr_i(ram_b_addr), .b_we_i(ram_b_we),
        .b_wdata_i(ram_b_wdata), .b_rdata_o(ram_b_rdata)
    );

endmodule

// File: design/dmem_ctrl.sv
module dmem_ctrl (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              rd_req_valid_i,
    input  conv_pkg::rd_req_t rd_req_i,
    output logic              rd_req_ready_o,
    output logic              rd_data_valid_o,
    output conv_pkg::word_t   rd_data_o,
    input  logic              rd_data_ready_i,
    input  logic              wr_req_valid_i,
    input  conv_pkg::wr_req_t wr_req_i,
    output logic              wr_req_ready_o,
    input  logic              wr_data_valid_i,
    input  conv_pkg::word_t   wr_data_i,
    output logic              wr_data_ready_o,
    output logic              wr_resp_valid_o,
    input  logic              wr_resp_ready_i,
    output conv_pkg::addr_t   ram_addr_o,
    output logic              ram_we_o,
    output conv_pkg::word_t   ram_wdata_o,
    input  conv_pkg::word_t   ram_rdata_i
);
    conv_pkg::addr_t addr_q;
    conv_pkg::len_t  cnt_q;         // words left to issue
    logic            rd_act;
    logic            wr_act;
    logic            inflight;      // ram word shows up this cycle
    logic            hold_valid;
    conv_pkg::word_t hold_q;
    logic            free;
    logic            rd_issue;
    logic            wr_beat;
    logic            hold_load;

    assign free            = !rd_act && !wr_act && !inflight && !hold_valid && !wr_resp_valid_o;
    assign rd_req_ready_o  = free;
    assign wr_req_ready_o  = free && !rd_req_valid_i;    // reads win ties
    assign rd_issue        = rd_act && !hold_valid && (!inflight || rd_data_ready_i);
    assign wr_data_ready_o = wr_act;
    assign wr_beat         = wr_data_valid_i && wr_act;
    assign hold_load       = inflight && !rd_data_ready_i && !hold_valid;

    assign rd_data_valid_o = inflight || hold_valid;
    assign rd_data_o       = hold_valid ? hold_q : ram_rdata_i;
    assign ram_addr_o      = addr_q;
    assign ram_we_o        = wr_beat;
    assign ram_wdata_o     = wr_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_act          <= 1'b0;
            wr_act          <= 1'b0;
            inflight        <= 1'b0;
            hold_valid      <= 1'b0;
            wr_resp_valid_o <= 1'b0;
            cnt_q           <= '0;
        end else begin
            inflight <= rd_issue;
            if (rd_req_valid_i && rd_req_ready_o) begin
                rd_act <= 1'b1;
                cnt_q  <= rd_req_i.len;
            end else if (wr_req_valid_i && wr_req_ready_o) begin
                wr_act <= 1'b1;
                cnt_q  <= wr_req_i.len;
            end else if (rd_issue || wr_beat) begin
                cnt_q <= cnt_q - 5'd1;
                if (cnt_q == 5'd1) begin    // last word of the burst
                    rd_act          <= 1'b0;
                    wr_act          <= 1'b0;
                    wr_resp_valid_o <= wr_act;
                end
            end
            if (hold_load) begin
                hold_valid <= 1'b1;
            end else if (hold_valid && rd_data_ready_i) begin
                hold_valid <= 1'b0;
            end
            if (wr_resp_valid_o && wr_resp_ready_i) begin
                wr_resp_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_valid_i && rd_req_ready_o) begin
            addr_q <= rd_req_i.addr;
        end else if (wr_req_valid_i && wr_req_ready_o) begin
            addr_q <= wr_req_i.addr;
        end else if (rd_issue || wr_beat) begin
            addr_q <= addr_q + 1'b1;
        end
        if (hold_load) begin
            hold_q <= ram_rdata_i;
        end
    end

endmodule

// File: design/dmem_ram.sv
`include "conv_config.svh"

module dmem_ram (
    input  logic            clk,
    input  conv_pkg::addr_t a_addr_i,
    input  logic            a_we_i,
    input  conv_pkg::word_t a_wdata_i,
    output conv_pkg::word_t a_rdata_o,
    input  conv_pkg::addr_t b_addr_i,
    input  logic            b_we_i,
    input  conv_pkg::word_t b_wdata_i,
    output conv_pkg::word_t b_rdata_o
);
    conv_pkg::word_t mem [`CONV_MEM_DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;    // host port
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;    // engine port
        end
        a_rdata_o <= mem[a_addr_i];
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conv_tb -f tb.f -o sim_conv

./obj_dir/sim_conv > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb.f
+incdir+design
design/conv_pkg.sv
design/dmem_ram.sv
design/dmem_ctrl.sv
design/conv_regs.sv
design/conv_engine.sv
design/conv_top.sv
verification/conv_properties.sv
verification/conv_tb.sv

// File: verification/conv_properties.sv
module conv_properties (
    input logic              clk,
    input logic              rst_i,
    input logic              start_i,
    input logic              idle_i,
    input logic              rq_valid_i,
    input logic              rq_ready_i,
    input conv_pkg::rd_req_t rq_i,
    input logic              rd_valid_i,
    input logic              rd_ready_i,
    input conv_pkg::word_t   rd_i,
    input logic              wq_valid_i,
    input logic              wq_ready_i,
    input conv_pkg::wr_req_t wq_i,
    input logic              wd_valid_i,
    input logic              wd_ready_i,
    input conv_pkg::word_t   wd_i,
    input logic              resp_valid_i,
    input logic              resp_ready_i
);
    logic data_seen;    // write beat taken, response still owed

    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_seen <= 1'b0;
        end else if (wd_valid_i && wd_ready_i) begin
            data_seen <= 1'b1;
        end else if (resp_valid_i && resp_ready_i) begin
            data_seen <= 1'b0;
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (rst_i)
        start_i |-> idle_i)
        else $error("start pulse while the engine is busy");

    rd_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        rq_valid_i && !rq_ready_i |=> rq_valid_i && $stable(rq_i))
        else $error("read request dropped or changed before ready");

    rd_data_hold: assert property (@(posedge clk) disable iff (rst_i)
        rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_i))
        else $error("read data dropped or changed before ready");

    wr_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        wq_valid_i && !wq_ready_i |=> wq_valid_i && $stable(wq_i))
        else $error("write request dropped or changed before ready");

    wr_data_hold: assert property (@(posedge clk) disable iff (rst_i)
        wd_valid_i && !wd_ready_i |=> wd_valid_i && $stable(wd_i))
        else $error("write data dropped or changed before ready");

    resp_hold: assert property (@(posedge clk) disable iff (rst_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i)
        else $error("write response dropped before ready");

    resp_after_data: assert property (@(posedge clk) disable iff (rst_i)
        resp_valid_i |-> data_seen)
        else $error("write response without a write data beat");

endmodule

bind conv_engine conv_properties i_props (
    .clk(clk), .rst_i(rst_i), .start_i(start_i), .idle_i(idle_o),
    .rq_valid_i(rd_req_valid_o), .rq_ready_i(rd_req_ready_i), .rq_i(rd_req_o),
    .rd_valid_i(rd_data_valid_i), .rd_ready_i(rd_data_ready_o), .rd_i(rd_data_i),
    .wq_valid_i(wr_req_valid_o), .wq_ready_i(wr_req_ready_i), .wq_i(wr_req_o),
    .wd_valid_i(wr_data_valid_o), .wd_ready_i(wr_data_ready_i), .wd_i(wr_data_o),
    .resp_valid_i(wr_resp_valid_i), .resp_ready_i(wr_resp_ready_o)
);

// controller side has no start, so that check is tied off here
bind dmem_ctrl conv_properties i_props (
    .clk(clk), .rst_i(rst_i), .start_i(1'b0), .idle_i(1'b1),
    .rq_valid_i(rd_req_valid_i), .rq_ready_i(rd_req_ready_o), .rq_i(rd_req_i),
    .rd_valid_i(rd_data_valid_o), .rd_ready_i(rd_data_ready_i), .rd_i(rd_data_o),
    .wq_valid_i(wr_req_valid_i), .wq_ready_i(wr_req_ready_o), .wq_i(wr_req_i),
    .wd_valid_i(wr_data_valid_i), .wd_ready_i(wr_data_ready_o), .wd_i(wr_data_i),
    .resp_valid_i(wr_resp_valid_o), .resp_ready_i(wr_resp_ready_i)
);

// File: verification/conv_tb.sv
`include "conv_config.svh"

module conv_tb;
    localparam logic [31:0] REG_WIN    = 32'h1 << `CONV_REG_SEL_BIT;
    localparam int          POLL_LIMIT = 4000;
    localparam int          K          = `CONV_WT_DIM;

    logic                clk;
    logic                rst_i;
    logic                host_valid;
    conv_pkg::host_req_t host_req;
    conv_pkg::word_t     host_rdata;
    logic                host_rvalid;

    int mismatches;
    int other_errors;
    int wt_arr [K*K];    // shadow of what the host wrote
    int ifm_arr [`CONV_MAX_FM_DIM*`CONV_MAX_FM_DIM];

    conv_top i_dut (
        .clk(clk), .rst_i(rst_i),
        .host_valid_i(host_valid), .host_req_i(host_req),
        .host_rdata_o(host_rdata), .host_rvalid_o(host_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input conv_pkg::word_t got,
                                   input conv_pkg::word_t expected);
        mismatches++;
        $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
    endtask

    task automatic host_write(input logic [31:0] addr, input conv_pkg::word_t data);
        @(posedge clk);
        #10;
        host_valid     = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = data;
        host_req.we    = 1'b1;
        @(posedge clk);
        #10;
        host_valid  = 1'b0;
        host_req.we = 1'b0;
    endtask

    task automatic host_read(input logic [31:0] addr, output conv_pkg::word_t data);
        @(posedge clk);
        #10;
        host_valid    = 1'b1;
        host_req.addr = addr;
        host_req.we   = 1'b0;
        @(posedge clk);
        #10;
        host_valid = 1'b0;
        data       = host_rdata;    // registered, stable until the next edge
        if (host_rvalid !== 1'b1) begin
            other_errors++;
            $display("read of address %h got no response one cycle later", addr);
        end
    endtask

    task automatic wait_done(output bit timed_out);
        conv_pkg::word_t status;
        int              polls;
        status    = '0;
        polls     = 0;
        timed_out = 1'b0;
        while (status[1] !== 1'b1 && !timed_out) begin
            if (polls == POLL_LIMIT) begin
                other_errors++;
                timed_out = 1'b1;
                $display("convolution not done after %0d status polls", POLL_LIMIT);
            end else begin
                host_read(REG_WIN | `CONV_REG_STATUS, status);
                polls++;
            end
        end
    endtask

    // valid convolution, int arithmetic wraps mod 2^32
    function automatic int compute_ref(input int fm_dim, input int r, input int c);
        int sum;
        sum = 0;
        for (int i = 0; i < K; i++) begin
            for (int j = 0; j < K; j++) begin
                sum += wt_arr[i*K+j] * ifm_arr[(r+i)*fm_dim + c + j];
            end
        end
        return sum;
    endfunction

    task automatic load_maps(input int fm_dim, input int wt_ofs, input int ifm_ofs);
        for (int k = 0; k < K*K; k++) begin
            host_write(wt_ofs + k, wt_arr[k]);
        end
        for (int k = 0; k < fm_dim*fm_dim; k++) begin
            host_write(ifm_ofs + k, ifm_arr[k]);
        end
    endtask

    task automatic configure(input int fm_dim, input int wt_ofs, input int ifm_ofs,
                             input int ofm_ofs);
        host_write(REG_WIN | `CONV_REG_FM_DIM, fm_dim);
        host_write(REG_WIN | `CONV_REG_WT_OFS, wt_ofs);
        host_write(REG_WIN | `CONV_REG_IFM_OFS, ifm_ofs);
        host_write(REG_WIN | `CONV_REG_OFM_OFS, ofm_ofs);
    endtask

    task automatic start_run();
        host_write(REG_WIN | `CONV_REG_CTRL, 32'h1);
    endtask

    task automatic check_results(input int fm_dim, input int ofm_ofs);
        conv_pkg::word_t rd;
        int              out_dim;
        int              expected;
        out_dim = fm_dim - K + 1;
        for (int r = 0; r < out_dim; r++) begin
            for (int c = 0; c < out_dim; c++) begin
                host_read(ofm_ofs + r * out_dim + c, rd);
                expected = compute_ref(fm_dim, r, c);
                if (rd !== expected) begin
                    report_mismatch($sformatf("output (%0d,%0d)", r, c), rd, expected);
                end
            end
        end
    endtask

    task automatic test_reset_status();
        conv_pkg::word_t rd;
        host_read(REG_WIN | `CONV_REG_STATUS, rd);
        if (rd !== 32'h1) begin
            report_mismatch("status after reset", rd, 32'h1);
        end
    endtask

    task automatic test_reg_readback();
        conv_pkg::word_t rd;
        int              vals [4];
        vals = '{7, 'h0123, 'h1abc, 'h3fff};
        configure(vals[0], vals[1], vals[2], vals[3]);
        for (int k = 0; k < 4; k++) begin
            host_read(REG_WIN | (`CONV_REG_FM_DIM + k), rd);    // fm_dim then the offsets
            if (rd !== vals[k]) begin
                report_mismatch($sformatf("register %0d", `CONV_REG_FM_DIM + k), rd, vals[k]);
            end
        end
    endtask

    task automatic test_mem_random();
        conv_pkg::word_t data [16];
        conv_pkg::word_t rd;
        for (int k = 0; k < 16; k++) begin
            data[k] = $urandom();
            host_write(32'h3000 + k, data[k]);
        end
        for (int k = 0; k < 16; k++) begin
            host_read(32'h3000 + k, rd);
            if (rd !== data[k]) begin
                report_mismatch($sformatf("memory word %0d", k), rd, data[k]);
            end
        end
    endtask

    task automatic test_ones_ramp();
        conv_pkg::word_t rd;
        bit              timed_out;
        int              expected;
        for (int k = 0; k < K*K; k++) begin
            wt_arr[k] = 1;
        end
        for (int k = 0; k < 64; k++) begin
            ifm_arr[k] = k;
        end
        load_maps(8, 'h100, 'h200);
        configure(8, 'h100, 'h200, 'h400);
        start_run();
        wait_done(timed_out);
        if (!timed_out) begin
            for (int r = 0; r < 6; r++) begin
                for (int c = 0; c < 6; c++) begin
                    host_read(32'h400 + r * 6 + c, rd);
                    expected = 9 * (8 * r + c + 9);    // nine times the window centre
                    if (rd !== expected) begin
                        report_mismatch($sformatf("ramp output (%0d,%0d)", r, c), rd, expected);
                    end
                end
            end
        end
    endtask

    task automatic test_random_signed();
        conv_pkg::word_t rd;
        conv_pkg::word_t sentinel;
        bit              timed_out;
        for (int k = 0; k < K*K; k++) begin
            wt_arr[k] = int'($urandom_range(255)) - 128;
        end
        for (int k = 0; k < 25; k++) begin
            ifm_arr[k] = $urandom();    // full range, products wrap
        end
        load_maps(5, 'h500, 'h600);
        sentinel = $urandom();
        host_write(32'h700 + 9, sentinel);    // first word past a 3x3 output map
        configure(5, 'h500, 'h600, 'h700);
        start_run();
        wait_done(timed_out);
        if (!timed_out) begin
            check_results(5, 'h700);
            host_read(32'h700 + 9, rd);
            if (rd !== sentinel) begin
                report_mismatch("word past the output map", rd, sentinel);
            end
        end
    endtask

    task automatic test_busy_start();
        conv_pkg::word_t rd;
        bit              timed_out;
        for (int k = 0; k < 25; k++) begin
            ifm_arr[k] = $urandom();
        end
        load_maps(5, 'h500, 'h600);
        start_run();
        host_read(REG_WIN | `CONV_REG_STATUS, rd);
        if (rd !== 32'h0) begin
            report_mismatch("status after start", rd, 32'h0);
        end
        start_run();    // busy, must be dropped
        host_read(REG_WIN | `CONV_REG_STATUS, rd);
        if (rd !== 32'h0) begin
            report_mismatch("status after start while busy", rd, 32'h0);
        end
        wait_done(timed_out);
        if (!timed_out) begin
            check_results(5, 'h700);
            start_run();
            host_read(REG_WIN | `CONV_REG_STATUS, rd);
            if (rd !== 32'h0) begin
                report_mismatch("status after a fresh start", rd, 32'h0);
            end
            wait_done(timed_out);
        end
    endtask

    initial begin
        int seed_ret;
        rst_i        = 1'b1;
        host_valid   = 1'b0;
        host_req     = '0;
        mismatches   = 0;
        other_errors = 0;
        seed_ret     = $urandom(32'h15b6);
        repeat (10) @(posedge clk);
        #10;
        rst_i = 1'b0;
        test_reset_status();
        test_reg_readback();
        test_mem_random();
        test_ones_ramp();
        test_random_signed();
        test_busy_start();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
